//--- build.f
design/ltssm_pkg.sv
design/ts_pkg.sv
design/ltssm_ctrl.sv
design/ts_generator.sv
design/ts_analyzer.sv
design/ltssm_top.sv
verif/ltssm_properties.sv
verif/ltssm_tb.sv

//--- design/ltssm_ctrl.sv
`timescale 1ns/1ps

module ltssm_ctrl #(
   parameter int NUM_LANES = 4
) (
   input  logic                    clk_i,
   input  logic                    arst_n_i,
   input  ltssm_pkg::lane_mask_t   elec_idle_brk_i,
   input  ltssm_pkg::lane_mask_t   rx_det_i,
   input  ltssm_pkg::lane_mask_t   rx_det_seq_ack_i,
   input  ltssm_pkg::lane_mask_t   lane_ready_i,
   output ltssm_pkg::lane_mask_t   rx_det_seq_req_o,
   output ltssm_pkg::lane_mask_t   active_lanes_o,
   output ltssm_pkg::ltssm_state_t state_o,
   output logic                    linkup_o
);
   import ltssm_pkg::*;

   localparam lane_mask_t ALL_LANES = lane_mask_t'((1 << NUM_LANES) - 1);

   ltssm_state_t state_q;
   ltssm_state_t state_d;
   lane_mask_t   req_q;        // outstanding detect requests
   lane_mask_t   ack_seen_q;   // lanes that already acknowledged
   lane_mask_t   ack_done;
   lane_mask_t   active_q;     // lanes with a receiver, from Detect
   cnt_t         idle_cnt_q;
   logic         all_ready;
   logic         idle_done;
   logic         detect_done;

   assign ack_done    = ack_seen_q | (req_q & rx_det_seq_ack_i);
   assign detect_done = (ack_done == ALL_LANES);
   assign all_ready   = ((lane_ready_i & active_q) == active_q);
   assign idle_done   = (idle_cnt_q == cnt_t'(IDLE_CYCLES - 5'd1));

   always_comb begin
      state_d = state_q;
      case (state_q)
         DETECT_QUIET: begin
            if (|elec_idle_brk_i)
               state_d = DETECT_ACTIVE;
         end
         DETECT_ACTIVE: begin
            if (detect_done)
               state_d = (rx_det_i == '0) ? DETECT_QUIET : POLL_ACTIVE;
         end
         POLL_ACTIVE: begin
            if (all_ready)
               state_d = POLL_CONFIG;
         end
         POLL_CONFIG: begin
            if (all_ready)
               state_d = CFG_LWIDTH_START;
         end
         CFG_LWIDTH_START: begin
            if (all_ready)
               state_d = CFG_LANENUM_WAIT;
         end
         CFG_LANENUM_WAIT: begin
            if (all_ready)
               state_d = CFG_COMPLETE;
         end
         CFG_COMPLETE: begin
            if (all_ready)
               state_d = CFG_IDLE;
         end
         CFG_IDLE: begin
            if (idle_done)
               state_d = L0;
         end
         L0:      state_d = L0;            // no recovery, held until reset
         default: state_d = DETECT_QUIET;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= DETECT_QUIET;
         req_q      <= '0;
         ack_seen_q <= '0;
         active_q   <= '0;
         idle_cnt_q <= '0;
      end else begin
         state_q <= state_d;

         if (state_q == DETECT_ACTIVE) begin
            req_q      <= ~ack_done;        // request until acknowledged
            ack_seen_q <= ack_done;
         end else begin
            req_q      <= '0;
            ack_seen_q <= '0;
         end

         if (state_q == DETECT_ACTIVE && detect_done)
            active_q <= rx_det_i;           // lane set for the rest of training

         if (state_q == CFG_IDLE)
            idle_cnt_q <= idle_cnt_q + 5'd1;
         else
            idle_cnt_q <= '0;
      end
   end

   assign state_o          = state_q;
   assign active_lanes_o   = active_q;
   assign rx_det_seq_req_o = req_q;
   assign linkup_o         = (state_q == L0);

endmodule

//--- design/ltssm_pkg.sv
package ltssm_pkg;

   // link states in training order
   typedef enum logic [3:0] {
      DETECT_QUIET     = 4'd0,  // waiting for electrical idle break
      DETECT_ACTIVE    = 4'd1,  // receiver detect handshake
      POLL_ACTIVE      = 4'd2,  // TS1 exchange with PAD numbers
      POLL_CONFIG      = 4'd3,  // TS2 exchange with PAD numbers
      CFG_LWIDTH_START = 4'd4,  // link number offered by the DSP
      CFG_LANENUM_WAIT = 4'd5,  // lane numbers offered and echoed
      CFG_COMPLETE     = 4'd6,  // TS2 with final numbers
      CFG_IDLE         = 4'd7,  // quiet period before L0
      L0               = 4'd8   // link up
   } ltssm_state_t;

   // one bit per lane, lane 0 in bit 0
   typedef logic [3:0] lane_mask_t;

   // wide enough for every count below
   typedef logic [4:0] cnt_t;

   // sets a lane sends in a phase before the phase may end
   localparam cnt_t TX_MIN_COUNT = 5'd16;

   // consecutive matching sets in Polling and Complete
   localparam cnt_t POLL_RX_COUNT = 5'd8;

   // consecutive matching TS1 sets in link-width and lane-number phases
   localparam cnt_t CFG_RX_COUNT = 5'd2;

   // clocks spent in Configuration.Idle
   localparam cnt_t IDLE_CYCLES = 5'd16;

   // states in which training sets are exchanged
   function automatic logic is_ts_phase(ltssm_state_t st);
      logic res;
      res = (st == POLL_ACTIVE) || (st == POLL_CONFIG) ||
            (st == CFG_LWIDTH_START) || (st == CFG_LANENUM_WAIT) ||
            (st == CFG_COMPLETE);
      return res;
   endfunction

endpackage

//--- design/ltssm_top.sv
`timescale 1ns/1ps

module ltssm_top #(
   parameter int              NUM_LANES   = 4,
   parameter int              TS_INTERVAL = 4,
   parameter ts_pkg::symbol_t LINK_NUM    = 8'h01
) (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  logic                  mode_i,                 // 0 DSP, 1 USP
   input  ltssm_pkg::lane_mask_t elec_idle_brk_i,
   input  ltssm_pkg::lane_mask_t rx_det_i,
   input  ltssm_pkg::lane_mask_t rx_det_seq_ack_i,
   output ltssm_pkg::lane_mask_t rx_det_seq_req_o,
   input  ts_pkg::ts_t           ts_i [NUM_LANES],
   input  logic [NUM_LANES-1:0]  ts_vld_i,
   output ts_pkg::ts_t           ts_o [NUM_LANES],
   output logic [NUM_LANES-1:0]  ts_vld_o,
   input  logic [NUM_LANES-1:0]  tx_fifo_full_i,
   output logic                  linkup_o
);
   import ltssm_pkg::*;
   import ts_pkg::*;

   ltssm_state_t state;          // broadcast to all lanes
   lane_mask_t   active_lanes;
   lane_mask_t   lane_ready;

   ltssm_ctrl #(
      .NUM_LANES (NUM_LANES)
   ) u_ctrl (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .elec_idle_brk_i  (elec_idle_brk_i),
      .rx_det_i         (rx_det_i),
      .rx_det_seq_ack_i (rx_det_seq_ack_i),
      .lane_ready_i     (lane_ready),
      .rx_det_seq_req_o (rx_det_seq_req_o),
      .active_lanes_o   (active_lanes),
      .state_o          (state),
      .linkup_o         (linkup_o)
   );

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      logic    sent_enough;
      symbol_t rcv_link;
      symbol_t rcv_lane;

      ts_generator #(
         .TS_INTERVAL (TS_INTERVAL),
         .LINK_NUM    (LINK_NUM),
         .LANE_IDX    (i)
      ) u_gen (
         .clk_i          (clk_i),
         .arst_n_i       (arst_n_i),
         .mode_i         (mode_i),
         .state_i        (state),
         .active_i       (active_lanes[i]),
         .tx_fifo_full_i (tx_fifo_full_i[i]),
         .rcv_link_i     (rcv_link),
         .rcv_lane_i     (rcv_lane),
         .ts_o           (ts_o[i]),
         .ts_vld_o       (ts_vld_o[i]),
         .sent_enough_o  (sent_enough)
      );

      ts_analyzer #(
         .LANE_IDX (i)
      ) u_ana (
         .clk_i         (clk_i),
         .arst_n_i      (arst_n_i),
         .state_i       (state),
         .ts_i          (ts_i[i]),
         .ts_vld_i      (ts_vld_i[i]),
         .sent_enough_i (sent_enough),
         .rcv_link_o    (rcv_link),
         .rcv_lane_o    (rcv_lane),
         .lane_ready_o  (lane_ready[i])
      );
   end

endmodule

//--- design/ts_analyzer.sv
`timescale 1ns/1ps

module ts_analyzer #(
   parameter int LANE_IDX = 0
) (
   input  logic                    clk_i,
   input  logic                    arst_n_i,
   input  ltssm_pkg::ltssm_state_t state_i,
   input  ts_pkg::ts_t             ts_i,
   input  logic                    ts_vld_i,
   input  logic                    sent_enough_i,
   output ts_pkg::symbol_t         rcv_link_o,
   output ts_pkg::symbol_t         rcv_lane_o,
   output logic                    lane_ready_o
);
   import ltssm_pkg::*;
   import ts_pkg::*;

   localparam symbol_t LANE_SYM = symbol_t'(LANE_IDX);

   ltssm_state_t state_prev_q;
   logic         phase_new;
   cnt_t         rx_cnt_q;       // consecutive matching sets
   symbol_t      link_q;
   symbol_t      lane_q;
   symbol_t      link_sym;
   symbol_t      lane_sym;
   logic         is_ts1;
   logic         is_ts2;
   logic         pad_pad;
   logic         match;
   logic         need_tx;        // phase also waits for own sent count
   cnt_t         need_rx;

   assign phase_new = (state_i != state_prev_q);
   assign link_sym  = get_sym(ts_i, IDX_LINK);
   assign lane_sym  = get_sym(ts_i, IDX_LANE);
   assign is_ts1    = (get_sym(ts_i, IDX_COM) == SYM_COM) && (get_sym(ts_i, IDX_ID) == TS1_ID);
   assign is_ts2    = (get_sym(ts_i, IDX_COM) == SYM_COM) && (get_sym(ts_i, IDX_ID) == TS2_ID);
   assign pad_pad   = (link_sym == SYM_PAD) && (lane_sym == SYM_PAD);

   always_comb begin
      match   = 1'b0;
      need_tx = 1'b0;
      need_rx = POLL_RX_COUNT;
      case (state_i)
         POLL_ACTIVE: begin
            match   = (is_ts1 | is_ts2) & pad_pad;
            need_tx = 1'b1;
         end
         POLL_CONFIG: begin
            match   = is_ts2 & pad_pad;
            need_tx = 1'b1;
         end
         CFG_LWIDTH_START: begin
            match   = is_ts1 & (link_sym != SYM_PAD);
            need_rx = CFG_RX_COUNT;
         end
         CFG_LANENUM_WAIT: begin
            match   = is_ts1 & (lane_sym == LANE_SYM);
            need_rx = CFG_RX_COUNT;
         end
         CFG_COMPLETE: begin
            match   = is_ts2 & (lane_sym == LANE_SYM);
            need_tx = 1'b1;
         end
         default: match = 1'b0;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_prev_q <= DETECT_QUIET;
         rx_cnt_q     <= '0;
         link_q       <= SYM_PAD;
         lane_q       <= SYM_PAD;
      end else begin
         state_prev_q <= state_i;

         if (phase_new)
            rx_cnt_q <= cnt_t'(ts_vld_i & match);
         else if (ts_vld_i && !match)
            rx_cnt_q <= '0;                 // run broken
         else if (ts_vld_i && rx_cnt_q != POLL_RX_COUNT)
            rx_cnt_q <= rx_cnt_q + 5'd1;

         // keep last real numbers for the USP echo
         if (ts_vld_i && (is_ts1 || is_ts2)) begin
            if (link_sym != SYM_PAD)
               link_q <= link_sym;
            if (lane_sym != SYM_PAD)
               lane_q <= lane_sym;
         end
      end
   end

   // counters still hold the previous phase on its first clock
   assign lane_ready_o = is_ts_phase(state_i) && !phase_new &&
                         (rx_cnt_q >= need_rx) && (sent_enough_i || !need_tx);
   assign rcv_link_o   = link_q;
   assign rcv_lane_o   = lane_q;

endmodule

//--- design/ts_generator.sv
`timescale 1ns/1ps

module ts_generator #(
   parameter int              TS_INTERVAL = 4,
   parameter ts_pkg::symbol_t LINK_NUM    = 8'h01,
   parameter int              LANE_IDX    = 0
) (
   input  logic                    clk_i,
   input  logic                    arst_n_i,
   input  logic                    mode_i,         // 0 DSP, 1 USP
   input  ltssm_pkg::ltssm_state_t state_i,
   input  logic                    active_i,
   input  logic                    tx_fifo_full_i,
   input  ts_pkg::symbol_t         rcv_link_i,
   input  ts_pkg::symbol_t         rcv_lane_i,
   output ts_pkg::ts_t             ts_o,
   output logic                    ts_vld_o,
   output logic                    sent_enough_o
);
   import ltssm_pkg::*;
   import ts_pkg::*;

   localparam int               GAP_W    = $clog2(TS_INTERVAL + 1);
   localparam logic [GAP_W-1:0] GAP_MAX  = GAP_W'(TS_INTERVAL);
   localparam symbol_t          LANE_SYM = symbol_t'(LANE_IDX);

   ltssm_state_t     state_prev_q;
   logic             phase_new;
   logic [GAP_W-1:0] gap_q;         // clocks since last set, saturating
   cnt_t             sent_cnt_q;
   symbol_t          id_sym;
   symbol_t          link_sym;
   symbol_t          lane_sym;

   assign phase_new = (state_i != state_prev_q);

   // a USP echoes what it got, the analyzer keeps PAD until a number arrives
   always_comb begin
      id_sym   = TS1_ID;
      link_sym = SYM_PAD;
      lane_sym = SYM_PAD;
      case (state_i)
         POLL_CONFIG: id_sym = TS2_ID;
         CFG_LWIDTH_START: begin
            link_sym = mode_i ? rcv_link_i : LINK_NUM;
         end
         CFG_LANENUM_WAIT, CFG_COMPLETE: begin
            if (state_i == CFG_COMPLETE)
               id_sym = TS2_ID;
            link_sym = mode_i ? rcv_link_i : LINK_NUM;
            lane_sym = mode_i ? rcv_lane_i : LANE_SYM;
         end
         default: id_sym = TS1_ID;
      endcase
   end

   assign ts_o     = build_ts(id_sym, link_sym, lane_sym);
   assign ts_vld_o = is_ts_phase(state_i) & active_i & (gap_q == GAP_MAX) & ~tx_fifo_full_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_prev_q <= DETECT_QUIET;
         gap_q        <= GAP_MAX;
         sent_cnt_q   <= '0;
      end else begin
         state_prev_q <= state_i;

         if (ts_vld_o)
            gap_q <= GAP_W'(1);
         else if (gap_q != GAP_MAX)
            gap_q <= gap_q + GAP_W'(1);

         if (phase_new)
            sent_cnt_q <= cnt_t'(ts_vld_o);  // fresh count per phase
         else if (ts_vld_o && sent_cnt_q != TX_MIN_COUNT)
            sent_cnt_q <= sent_cnt_q + 5'd1;
      end
   end

   assign sent_enough_o = (sent_cnt_q == TX_MIN_COUNT);

endmodule

//--- design/ts_pkg.sv
package ts_pkg;

   typedef logic [7:0]   symbol_t;
   typedef logic [127:0] ts_t;      // 16 symbols, symbol 0 in bits 7..0

   localparam symbol_t SYM_COM = 8'hBC;
   localparam symbol_t SYM_PAD = 8'hF7;
   localparam symbol_t TS1_ID  = 8'h4A;
   localparam symbol_t TS2_ID  = 8'h45;

   // symbol positions within a set
   localparam int IDX_COM  = 0;
   localparam int IDX_LINK = 1;
   localparam int IDX_LANE = 2;
   localparam int IDX_ID   = 3;

   // symbols 4..15 stay zero
   function automatic ts_t build_ts(symbol_t id, symbol_t link, symbol_t lane);
      ts_t ts;
      ts = '0;
      ts[IDX_COM*8  +: 8] = SYM_COM;
      ts[IDX_LINK*8 +: 8] = link;
      ts[IDX_LANE*8 +: 8] = lane;
      ts[IDX_ID*8   +: 8] = id;
      return ts;
   endfunction

   function automatic symbol_t get_sym(ts_t ts, int idx);
      symbol_t sym;
      sym = ts[idx*8 +: 8];
      return sym;
   endfunction

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module ltssm_tb -o sim_ltssm
out=$(./obj_dir/sim_ltssm)
echo "$out"
echo "$out" | grep -qx "RESULT: PASS"

//--- verif/ltssm_properties.sv
`timescale 1ns/1ps

module ltssm_properties #(
   parameter int NUM_LANES   = 4,
   parameter int TS_INTERVAL = 4
) (
   input logic                 clk_i,
   input logic                 arst_n_i,
   input logic [NUM_LANES-1:0] ts_vld_o,
   input logic [NUM_LANES-1:0] tx_fifo_full_i,
   input logic                 linkup_o
);

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      int gap_q;   // clocks since last set, saturating

      always_ff @(posedge clk_i or negedge arst_n_i) begin
         if (!arst_n_i)
            gap_q <= TS_INTERVAL;
         else if (ts_vld_o[i])
            gap_q <= 1;
         else if (gap_q < TS_INTERVAL)
            gap_q <= gap_q + 1;
      end

      a_no_send_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         !(ts_vld_o[i] && tx_fifo_full_i[i]))
         else $error("lane %0d sent a set while its TX FIFO was full", i);

      a_spacing: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         ts_vld_o[i] |-> gap_q >= TS_INTERVAL)
         else $error("lane %0d sent sets closer than %0d clocks", i, TS_INTERVAL);
   end

   a_linkup_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      linkup_o |=> linkup_o)
      else $error("linkup_o fell without a reset");

endmodule

bind ltssm_top ltssm_properties #(
   .NUM_LANES   (NUM_LANES),
   .TS_INTERVAL (TS_INTERVAL)
) u_props (
   .clk_i          (clk_i),
   .arst_n_i       (arst_n_i),
   .ts_vld_o       (ts_vld_o),
   .tx_fifo_full_i (tx_fifo_full_i),
   .linkup_o       (linkup_o)
);

//--- verif/ltssm_tb.sv
`timescale 1ns/1ps

module ltssm_tb;
   import ltssm_pkg::*;
   import ts_pkg::*;

   localparam int      NUM_LANES       = 4;
   localparam int      TS_INTERVAL     = 4;
   localparam symbol_t LINK_NUM        = 8'h01;
   localparam int      NUM_TRAIN       = 6;
   localparam int      LINK_TIMEOUT    = 1500;
   localparam int      WATCHDOG_CYCLES = NUM_TRAIN * 2000;

   logic       clk;
   logic       arst_n;
   logic       mode;               // 0 DSP, 1 USP
   lane_mask_t elec_idle_brk;
   lane_mask_t rx_det;
   lane_mask_t rx_det_seq_ack;
   lane_mask_t rx_det_seq_req;
   ts_t        ts_in  [NUM_LANES];
   ts_t        ts_out [NUM_LANES];
   logic [NUM_LANES-1:0] ts_vld_in;
   logic [NUM_LANES-1:0] ts_vld_out;
   logic [NUM_LANES-1:0] tx_fifo_full;
   logic       linkup;

   integer     seed = 36;
   int         errors;
   int         checks;

   // partner model, one entry per lane
   symbol_t    plink;              // link number a partner DSP offers
   logic       got      [NUM_LANES];
   logic       dut_ts2  [NUM_LANES];
   symbol_t    last_id  [NUM_LANES];
   symbol_t    last_link[NUM_LANES];
   symbol_t    last_lane[NUM_LANES];
   int         n_ts1pad [NUM_LANES];
   int         n_ts2pad [NUM_LANES];
   int         n_cpl    [NUM_LANES];  // DUT TS2 with numbers
   int         p_cpl    [NUM_LANES];  // partner TS2 with numbers
   int         gap      [NUM_LANES];
   int         idle_run;           // clocks since the last DUT set
   logic       brk_seen;
   logic       linkup_q;
   lane_mask_t prev_hs;            // request and acknowledge both seen

   ltssm_top #(
      .NUM_LANES   (NUM_LANES),
      .TS_INTERVAL (TS_INTERVAL),
      .LINK_NUM    (LINK_NUM)
   ) DUT (
      .clk_i            (clk),
      .arst_n_i         (arst_n),
      .mode_i           (mode),
      .elec_idle_brk_i  (elec_idle_brk),
      .rx_det_i         (rx_det),
      .rx_det_seq_ack_i (rx_det_seq_ack),
      .rx_det_seq_req_o (rx_det_seq_req),
      .ts_i             (ts_in),
      .ts_vld_i         (ts_vld_in),
      .ts_o             (ts_out),
      .ts_vld_o         (ts_vld_out),
      .tx_fifo_full_i   (tx_fifo_full),
      .linkup_o         (linkup)
   );

   always #50 clk = ~clk;

   function automatic ts_t make_set(symbol_t id, symbol_t lk, symbol_t ln);
      return {96'h0, id, ln, lk, SYM_COM};
   endfunction

   // remote port in the opposite role, reacting to the last set it got
   function automatic ts_t partner_set(int l);
      symbol_t id;
      symbol_t lk;
      symbol_t ln;
      id = TS1_ID;
      lk = SYM_PAD;
      ln = SYM_PAD;
      if (got[l]) begin
         if (last_id[l] == TS2_ID)
            id = TS2_ID;
         if (dut_ts2[l] && !(last_id[l] == TS2_ID && last_link[l] == SYM_PAD)) begin
            if (mode) begin                     // partner is the DSP
               lk = plink;
               ln = (last_link[l] != SYM_PAD) ? symbol_t'(l) : SYM_PAD;
            end else begin                      // partner echoes
               lk = last_link[l];
               ln = last_lane[l];
            end
         end
      end
      return make_set(id, lk, ln);
   endfunction

   task automatic clear_model();
      for (int l = 0; l < NUM_LANES; l++) begin
         got[l]      = 1'b0;
         dut_ts2[l]  = 1'b0;
         last_id[l]  = SYM_PAD;
         last_link[l] = SYM_PAD;
         last_lane[l] = SYM_PAD;
         n_ts1pad[l] = 0;
         n_ts2pad[l] = 0;
         n_cpl[l]    = 0;
         p_cpl[l]    = 0;
         gap[l]      = 0;
      end
      idle_run = 0;
      brk_seen = 1'b0;
      linkup_q = 1'b0;
      prev_hs  = '0;
   endtask

   // one clock of partner stimulus, 1 ns after the rising edge
   task automatic step_cycle(input logic driving);
      int r;
      @(posedge clk);
      #1;
      for (int l = 0; l < NUM_LANES; l++) begin
         r = $random(seed);
         ts_vld_in[l]      = 1'b0;
         rx_det_seq_ack[l] = rx_det_seq_req[l] && (r[1:0] == 2'd0);
         tx_fifo_full[l]   = driving && (r[4:2] == 3'd0);
         if (driving && rx_det[l]) begin
            if (gap[l] > 0) begin
               gap[l] = gap[l] - 1;
            end else begin
               ts_in[l]     = partner_set(l);
               ts_vld_in[l] = 1'b1;
               if (ts_in[l][31:24] == TS2_ID && ts_in[l][23:16] != SYM_PAD)
                  p_cpl[l] = p_cpl[l] + 1;
               gap[l] = TS_INTERVAL - 1 + int'(r[6:5]);
            end
         end
      end
   endtask

   task automatic check_set(int l, ts_t ts);
      symbol_t id;
      symbol_t lk;
      symbol_t ln;
      symbol_t exp_link;
      lk = ts[15:8];
      ln = ts[23:16];
      id = ts[31:24];
      exp_link = mode ? plink : LINK_NUM;
      checks = checks + 1;
      if (ts[7:0] != SYM_COM) begin
         errors = errors + 1;
         $display("FAILED ts_o[%0d] symbol 0: got %h expected %h", l, ts[7:0], SYM_COM);
      end
      if (id != TS1_ID && id != TS2_ID) begin
         errors = errors + 1;
         $display("FAILED ts_o[%0d] symbol 3: got %h expected %h or %h", l, id, TS1_ID, TS2_ID);
      end
      if (ts[127:32] != '0) begin
         errors = errors + 1;
         $display("FAILED ts_o[%0d] symbols 4..15: got %h expected 0", l, ts[127:32]);
      end
      if (lk != SYM_PAD) begin
         if (n_ts2pad[l] < int'(TX_MIN_COUNT)) begin
            errors = errors + 1;
            $display("lane %0d left Polling after only %0d TS2 sets", l, n_ts2pad[l]);
         end
         if (lk != exp_link) begin
            errors = errors + 1;
            $display("FAILED ts_o[%0d] link number: got %h expected %h", l, lk, exp_link);
         end
      end
      if (ln != SYM_PAD && ln != symbol_t'(l)) begin
         errors = errors + 1;
         $display("FAILED ts_o[%0d] lane number: got %h expected %h", l, ln, symbol_t'(l));
      end
      if (id == TS2_ID && lk == SYM_PAD && ln == SYM_PAD) begin
         if (!dut_ts2[l] && n_ts1pad[l] < int'(TX_MIN_COUNT)) begin
            errors = errors + 1;
            $display("lane %0d moved to TS2 after only %0d TS1 sets", l, n_ts1pad[l]);
         end
         n_ts2pad[l] = n_ts2pad[l] + 1;
         dut_ts2[l]  = 1'b1;
      end else if (id == TS1_ID && lk == SYM_PAD && ln == SYM_PAD && !dut_ts2[l]) begin
         n_ts1pad[l] = n_ts1pad[l] + 1;
      end
      if (id == TS2_ID && ln != SYM_PAD)
         n_cpl[l] = n_cpl[l] + 1;
      got[l]       = 1'b1;
      last_id[l]   = id;
      last_link[l] = lk;
      last_lane[l] = ln;
   endtask

   // outputs sampled at the falling edge, where they are stable
   always @(negedge clk) begin
      if (arst_n) begin
         if (elec_idle_brk != '0)
            brk_seen = 1'b1;
         if (linkup && !linkup_q) begin
            checks = checks + 1;
            if (idle_run < int'(IDLE_CYCLES)) begin
               errors = errors + 1;
               $display("a set went out %0d clocks before linkup_o rose", idle_run);
            end
            for (int l = 0; l < NUM_LANES; l++) begin
               if (rx_det[l] && (n_cpl[l] < int'(TX_MIN_COUNT) ||
                                 p_cpl[l] < int'(POLL_RX_COUNT))) begin
                  errors = errors + 1;
                  $display("linkup_o rose before lane %0d finished Configuration", l);
               end
            end
         end
         if (!brk_seen && (ts_vld_out != '0 || linkup || rx_det_seq_req != '0)) begin
            errors = errors + 1;
            $display("DUT became active before any electrical idle break");
         end
         for (int l = 0; l < NUM_LANES; l++) begin
            if (rx_det_seq_req[l] && prev_hs[l]) begin
               errors = errors + 1;
               $display("rx_det_seq_req_o[%0d] stayed high after its acknowledge", l);
            end
            if (ts_vld_out[l] && tx_fifo_full[l]) begin
               errors = errors + 1;
               $display("lane %0d sent a set while its TX FIFO was full", l);
            end
            if (ts_vld_out[l] && (!rx_det[l] || linkup)) begin
               errors = errors + 1;
               $display("lane %0d sent a set outside training on its active lanes", l);
            end
            if (ts_vld_out[l])
               check_set(l, ts_out[l]);
         end
         idle_run = (ts_vld_out != '0) ? 0 : idle_run + 1;
         prev_hs  = rx_det_seq_req & rx_det_seq_ack;
         linkup_q = linkup;
      end
   end

   task automatic run_training(int t);
      int r;
      int cyc;
      r = $random(seed);
      @(posedge clk);
      #1;
      arst_n        = 1'b0;
      elec_idle_brk = '0;
      mode          = r[0];
      rx_det        = r[4:1];
      if (rx_det == '0)
         rx_det = 4'b0001;
      plink = {1'b0, r[11:5]};     // never PAD
      clear_model();
      repeat (10) step_cycle(1'b0);
      arst_n = 1'b1;
      repeat (3 + int'(r[14:12])) step_cycle(1'b1);
      elec_idle_brk = r[19:16] | 4'b1000;
      cyc = 0;
      while (!linkup && cyc < LINK_TIMEOUT) begin
         step_cycle(1'b1);
         cyc = cyc + 1;
      end
      checks = checks + 1;
      if (!linkup) begin
         errors = errors + 1;
         $display("training %0d: linkup_o did not rise within %0d cycles", t, LINK_TIMEOUT);
      end
      repeat (20) step_cycle(1'b1);   // L0 stays quiet
   endtask

   initial begin
      clk            = 1'b0;
      arst_n         = 1'b0;
      mode           = 1'b0;
      elec_idle_brk  = '0;
      rx_det         = '0;
      rx_det_seq_ack = '0;
      ts_vld_in      = '0;
      tx_fifo_full   = '0;
      for (int l = 0; l < NUM_LANES; l++)
         ts_in[l] = '0;
      errors = 0;
      checks = 0;
      plink  = 8'h00;
      clear_model();
      for (int t = 0; t < NUM_TRAIN; t++)
         run_training(t);
      $display("trainings %0d checks %0d errors %0d", NUM_TRAIN, checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule
